//--- Bender.yml
package:
  name: plat_shim

sources:
  # Package first, then the blocks, then the top level
  - files:
      - rtl/plat_shim_pkg.sv
      - rtl/host_mmio_ingress.sv
      - rtl/afu_csr_block.sv
      - rtl/host_mmio_egress.sv
      - rtl/plat_shim_top.sv

  # Testbench, only for simulation
  - target: test
    files:
      - testbench/plat_shim_tb.sv

//--- rtl/afu_csr_block.sv
// Four 64-bit CSRs on Wishbone classic with a one-cycle registered ack; held in reset by afu_rst_n
`default_nettype none
`timescale 1ns/100ps

module afu_csr_block
    import plat_shim_pkg::*;
#(
    parameter logic [63:0] afu_id = 64'h0
)
(
    input  logic       ccip_to_afu,
    input  logic       afu_rst_n,
    input  pwr_state_t pwr_state,
    input  wb_req_t    wb_m,
    output wb_rsp_t    wb_s
);

    logic        ack_q;
    logic [63:0] rd_data_q;
    logic [63:0] rd_mux;
    logic [63:0] scratch;
    logic [63:0] wr_count;
    pwr_state_t  pwr_q;
    logic        access;
    logic        wr_access;

    // ========================================================================
    // Bus decode
    // ========================================================================

    // A cycle is served once, on the edge that raises ack
    // The master drops stb one cycle after ack, so ack_q keeps a second access out
    assign access    = wb_m.cyc && wb_m.stb && !ack_q;
    assign wr_access = access && wb_m.we;

    // Read data for the current address
    always_comb
    begin
        case (wb_m.adr)
            CSR_AFU_ID:    rd_mux = afu_id;
            CSR_SCRATCH:   rd_mux = scratch;
            CSR_WR_COUNT:  rd_mux = wr_count;
            CSR_PWR_STATE: rd_mux = {62'd0, pwr_q};
            default:       rd_mux = '0;
        endcase
    end

    // ========================================================================
    // Registers
    // ========================================================================

    always_ff @(posedge ccip_to_afu)
    begin
        if (!afu_rst_n)
        begin
            ack_q    <= 1'b0;
            scratch  <= '0;
            wr_count <= '0;
        end
        else
        begin
            ack_q <= access;
            // Only the scratch register takes write data
            if (wr_access && (wb_m.adr == CSR_SCRATCH))
                scratch <= wb_m.dat;
            // Every write counts, even to read-only or unmapped words
            if (wr_access)
                wr_count <= wr_count + 64'd1;
        end
    end

    // Read data goes out with ack
    always_ff @(posedge ccip_to_afu)
    begin
        if (access)
            rd_data_q <= rd_mux;
    end

    // Power state sampled once per cycle before it is read
    always_ff @(posedge ccip_to_afu)
    begin
        pwr_q <= pwr_state;
    end

    always_comb
    begin
        wb_s.ack = ack_q;
        wb_s.dat = rd_data_q;
    end

    // The slave only answers a cycle that the master still drives
    a_ack_needs_cycle: assert property (
        @(posedge ccip_to_afu) disable iff (!afu_rst_n)
        wb_s.ack |-> (wb_m.cyc && wb_m.stb)
    );

endmodule

`default_nettype wire

//--- rtl/host_mmio_egress.sv
// One-entry response holder; relies on the ingress not starting a read while rsp_busy is high
`default_nettype none
`timescale 1ns/100ps

module host_mmio_egress
    import plat_shim_pkg::*;
(
    input  logic      ccip_to_afu,
    input  logic      rst_n,
    input  wb_req_t   wb_m,
    input  wb_rsp_t   wb_s,
    output mmio_rsp_t host_rsp,
    input  logic      host_rsp_ready,
    output logic      rsp_busy
);

    logic        rsp_valid;
    logic [8:0]  rsp_tid;
    logic [63:0] rsp_data;
    logic        capture;
    logic        accept;

    // Only reads produce a response
    assign capture = wb_s.ack && !wb_m.we;
    assign accept  = rsp_valid && host_rsp_ready;

    always_ff @(posedge ccip_to_afu)
    begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else if (capture)
            rsp_valid <= 1'b1;
        else if (accept)
            rsp_valid <= 1'b0;
    end

    // Tag and data come from the same cycle as ack
    always_ff @(posedge ccip_to_afu)
    begin
        if (capture)
        begin
            rsp_tid  <= wb_m.tgc;
            rsp_data <= wb_s.dat;
        end
    end

    always_comb
    begin
        host_rsp = '{valid: rsp_valid, tid: rsp_tid, data: rsp_data};
    end

    assign rsp_busy = rsp_valid;

    // A waiting response must not be overwritten by a later read
    a_rsp_stable: assert property (
        @(posedge ccip_to_afu) disable iff (!rst_n)
        (host_rsp.valid && !host_rsp_ready) |=> $stable(host_rsp)
    );

endmodule

`default_nettype wire

//--- rtl/host_mmio_ingress.sv
// Needs queue_depth of at least 2; one Wishbone cycle in flight, reads held back while a response waits
`default_nettype none
`timescale 1ns/100ps

module host_mmio_ingress
    import plat_shim_pkg::*;
#(
    parameter int queue_depth = 2
)
(
    input  logic      ccip_to_afu,
    input  logic      rst_n,
    input  logic      soft_reset,
    input  mmio_req_t host_req,
    output logic      host_req_ready,
    output logic      afu_rst_n,
    output wb_req_t   wb_m,
    input  wb_rsp_t   wb_s,
    input  logic      rsp_busy
);

    localparam int ptr_w = $clog2(queue_depth);
    localparam int cnt_w = $clog2(queue_depth + 1);
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(queue_depth - 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(queue_depth);

    typedef enum logic {
        IDLE,
        BUS_CYCLE
    } state_e;

    state_e           state;
    mmio_req_t        queue_mem [queue_depth];
    mmio_req_t        head;
    mmio_req_t        cur_req;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_nxt;
    logic             push;
    logic             pop;

    // ========================================================================
    // Request queue
    // ========================================================================

    assign head = queue_mem[rd_ptr];
    assign push = host_req.valid && host_req_ready;
    // A read waits while the egress still holds the previous response
    assign pop  = (state == IDLE) && (count != '0) && ((head.op == MMIO_WRITE) || !rsp_busy);

    always_comb
    begin
        count_nxt = count;
        if (push && !pop)
            count_nxt = count + 1'b1;
        else if (pop && !push)
            count_nxt = count - 1'b1;
    end

    always_ff @(posedge ccip_to_afu)
    begin
        if (push)
            queue_mem[wr_ptr] <= host_req;
    end

    // Ready is registered from the next occupancy, so it rises one cycle after rst_n
    always_ff @(posedge ccip_to_afu)
    begin
        if (!rst_n)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            host_req_ready <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            count          <= count_nxt;
            host_req_ready <= (count_nxt != full_cnt);
        end
    end

    // ========================================================================
    // Wishbone master
    // ========================================================================

    always_ff @(posedge ccip_to_afu)
    begin
        if (!rst_n)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:      if (pop) state <= BUS_CYCLE;
                BUS_CYCLE: if (wb_s.ack) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // The popped request stays here as the bus payload until ack
    always_ff @(posedge ccip_to_afu)
    begin
        if (pop)
            cur_req <= head;
    end

    always_comb
    begin
        wb_m.cyc = (state == BUS_CYCLE);
        wb_m.stb = (state == BUS_CYCLE);
        wb_m.we  = (cur_req.op == MMIO_WRITE);
        wb_m.adr = cur_req.idx;
        wb_m.dat = cur_req.data;
        wb_m.tgc = cur_req.tid;
    end

    // Soft reset joins the platform reset here and reaches the AFU one cycle later
    always_ff @(posedge ccip_to_afu)
    begin
        afu_rst_n <= rst_n && !soft_reset;
    end

    // The slave may sample the payload on any cycle until it acknowledges
    a_wb_payload_stable: assert property (
        @(posedge ccip_to_afu) disable iff (!rst_n)
        (wb_m.stb && !wb_s.ack) |=> ($stable(wb_m.adr) && $stable(wb_m.dat))
    );

endmodule

`default_nettype wire

//--- rtl/plat_shim_pkg.sv
// Shared MMIO and Wishbone types for the shim; 64-bit data, 16-bit word index, 9-bit tag, no bursts
`default_nettype none

package plat_shim_pkg;

    // ========================================================================
    // Host MMIO channel
    // ========================================================================

    // Opcode of one host MMIO request
    typedef enum logic {
        MMIO_READ  = 1'b0,
        MMIO_WRITE = 1'b1
    } mmio_op_e;

    // One host request as it arrives on the MMIO channel
    // The tag in tid comes back unchanged with the read response
    typedef struct packed {
        logic        valid;
        mmio_op_e    op;
        logic [8:0]  tid;
        logic [15:0] idx;
        logic [63:0] data;
    } mmio_req_t;

    // One read response toward the host, writes never produce one
    typedef struct packed {
        logic        valid;
        logic [8:0]  tid;
        logic [63:0] data;
    } mmio_rsp_t;

    // ========================================================================
    // Wishbone classic link between the shim and the AFU
    // ========================================================================

    // Master side of the bus
    // The cycle tag tgc carries the host tid so that the egress can label the response
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [63:0] dat;
        logic [8:0]  tgc;
    } wb_req_t;

    // Slave side of the bus
    typedef struct packed {
        logic        ack;
        logic [63:0] dat;
    } wb_rsp_t;

    // Two-bit platform power state, passed through to the AFU as is
    typedef logic [1:0] pwr_state_t;

    // ========================================================================
    // CSR map, in 64-bit words
    // ========================================================================

    // Identity register, read only
    localparam logic [15:0] CSR_AFU_ID    = 16'd0;
    // General purpose scratch register
    localparam logic [15:0] CSR_SCRATCH   = 16'd1;
    // Count of acknowledged writes, read only
    localparam logic [15:0] CSR_WR_COUNT  = 16'd2;
    // Registered power state in bits 1:0, read only
    localparam logic [15:0] CSR_PWR_STATE = 16'd3;

endpackage

`default_nettype wire

//--- rtl/plat_shim_top.sv
// MMIO shim top; single clock ccip_to_afu, read latency 3 cycles from acceptance when the host is ready
`default_nettype none
`timescale 1ns/100ps

module plat_shim_top
    import plat_shim_pkg::*;
#(
    parameter logic [63:0] afu_id      = 64'h0,
    parameter int          queue_depth = 2
)
(
    input  logic       ccip_to_afu,
    input  logic       rst_n,
    input  logic       soft_reset,
    input  pwr_state_t pwr_state,
    input  mmio_req_t  host_req,
    output logic       host_req_ready,
    output mmio_rsp_t  host_rsp,
    input  logic       host_rsp_ready
);

    wb_req_t wb_m;
    wb_rsp_t wb_s;
    logic    afu_rst_n;
    logic    rsp_busy;

    // ========================================================================
    // Host requests into Wishbone cycles
    // ========================================================================

    host_mmio_ingress #(
        .queue_depth    (queue_depth)
    ) u_ingress (
        .ccip_to_afu    (ccip_to_afu),
        .rst_n          (rst_n),
        .soft_reset     (soft_reset),
        .host_req       (host_req),
        .host_req_ready (host_req_ready),
        .afu_rst_n      (afu_rst_n),
        .wb_m           (wb_m),
        .wb_s           (wb_s),
        .rsp_busy       (rsp_busy)
    );

    // AFU register block, cleared by the registered AFU reset
    afu_csr_block #(
        .afu_id      (afu_id)
    ) u_csr (
        .ccip_to_afu (ccip_to_afu),
        .afu_rst_n   (afu_rst_n),
        .pwr_state   (pwr_state),
        .wb_m        (wb_m),
        .wb_s        (wb_s)
    );

    // ========================================================================
    // Read data back to the host
    // ========================================================================

    host_mmio_egress u_egress (
        .ccip_to_afu    (ccip_to_afu),
        .rst_n          (rst_n),
        .wb_m           (wb_m),
        .wb_s           (wb_s),
        .host_rsp       (host_rsp),
        .host_rsp_ready (host_rsp_ready),
        .rsp_busy       (rsp_busy)
    );

endmodule

`default_nettype wire

//--- testbench/plat_shim_tb.sv
// Assumes queue_depth 2; drives on the rising edge and samples outputs on the falling edge
`default_nettype none
`timescale 1ns/100ps

module plat_shim_tb
    import plat_shim_pkg::*;
;

    localparam logic [63:0] test_afu_id = 64'hA5F0_1234_C0DE_0042;
    localparam int          wait_limit  = 50;

    logic       ccip_to_afu;
    logic       rst_n;
    logic       soft_reset;
    pwr_state_t pwr_state;
    mmio_req_t  host_req;
    logic       host_req_ready;
    mmio_rsp_t  host_rsp;
    logic       host_rsp_ready;

    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          err_mark;
    logic [63:0] exp_wr_count;
    logic [63:0] exp_scratch;
    logic [63:0] rnd;
    mmio_rsp_t   held;

    plat_shim_top #(
        .afu_id         (test_afu_id),
        .queue_depth    (2)
    ) dut0 (
        .ccip_to_afu    (ccip_to_afu),
        .rst_n          (rst_n),
        .soft_reset     (soft_reset),
        .pwr_state      (pwr_state),
        .host_req       (host_req),
        .host_req_ready (host_req_ready),
        .host_rsp       (host_rsp),
        .host_rsp_ready (host_rsp_ready)
    );

    // 10 ns clock period
    always #5 ccip_to_afu = ~ccip_to_afu;

    // ========================================================================
    // Host driver tasks
    // ========================================================================

    // Presents one request and holds it until the shim takes it
    // Ready is registered, so its value at the falling edge holds at the next rising edge
    task automatic send_req(input mmio_op_e op, input logic [8:0] tid,
                            input logic [15:0] idx, input logic [63:0] data);
        mmio_req_t req;
        int        waited;
        req.valid = 1'b1;
        req.op    = op;
        req.tid   = tid;
        req.idx   = idx;
        req.data  = data;
        waited    = 0;
        @(posedge ccip_to_afu);
        host_req <= req;
        @(negedge ccip_to_afu);
        while (!host_req_ready && waited < wait_limit)
        begin
            waited++;
            @(negedge ccip_to_afu);
        end
        if (!host_req_ready)
        begin
            errors++;
            $display("timeout at %0t: host_req_ready stayed low, request tid %h was not taken",
                     $time, tid);
        end
        @(posedge ccip_to_afu);
        host_req <= '0;
    endtask

    // Waits for the next response and compares tag and data
    // Called with host_rsp_ready high, so the response is taken at the following rising edge
    task automatic wait_rsp(input logic [8:0] exp_tid, input logic [63:0] exp_data);
        int waited;
        waited = 0;
        @(negedge ccip_to_afu);
        while (!host_rsp.valid && waited < wait_limit)
        begin
            waited++;
            @(negedge ccip_to_afu);
        end
        if (!host_rsp.valid)
        begin
            errors++;
            $display("timeout at %0t: no response arrived for tid %h", $time, exp_tid);
        end
        else
        begin
            checks += 2;
            if (host_rsp.tid !== exp_tid)
            begin
                errors++;
                $display("error at %0t: host_rsp.tid expected %h actual %h",
                         $time, exp_tid, host_rsp.tid);
            end
            if (host_rsp.data !== exp_data)
            begin
                errors++;
                $display("error at %0t: host_rsp.data expected %h actual %h",
                         $time, exp_data, host_rsp.data);
            end
        end
        @(posedge ccip_to_afu);
    endtask

    task automatic mmio_read(input logic [8:0] tid, input logic [15:0] idx,
                             input logic [63:0] exp_data);
        send_req(MMIO_READ, tid, idx, 64'd0);
        wait_rsp(tid, exp_data);
    endtask

    // Every write is counted by the CSR block whatever its index
    task automatic mmio_write(input logic [8:0] tid, input logic [15:0] idx,
                              input logic [63:0] data);
        send_req(MMIO_WRITE, tid, idx, data);
        exp_wr_count = exp_wr_count + 64'd1;
        if (idx == CSR_SCRATCH)
            exp_scratch = data;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s finished with %0d errors", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic test_reset_values();
        mmio_read(9'h011, CSR_AFU_ID, test_afu_id);
        mmio_read(9'h012, CSR_SCRATCH, 64'd0);
        mmio_read(9'h013, CSR_WR_COUNT, 64'd0);
        finish_test("reset values");
    endtask

    task automatic test_scratch_and_count();
        for (int i = 0; i < 4; i++)
        begin
            rnd = {$random(seed), $random(seed)};
            mmio_write(9'(9'h020 + i), CSR_SCRATCH, rnd);
            mmio_read(9'(9'h030 + i), CSR_SCRATCH, exp_scratch);
        end
        // Read-only and unmapped words still count as writes
        mmio_write(9'h040, CSR_AFU_ID, 64'hDEAD_BEEF_DEAD_BEEF);
        mmio_write(9'h041, 16'h0040, 64'h1234_5678_9ABC_DEF0);
        mmio_read(9'h042, CSR_AFU_ID, test_afu_id);
        mmio_read(9'h043, CSR_WR_COUNT, exp_wr_count);
        mmio_read(9'h044, 16'h0040, 64'd0);
        finish_test("scratch and write count");
    endtask

    task automatic test_power_state();
        @(posedge ccip_to_afu);
        pwr_state <= 2'b10;
        mmio_read(9'h050, CSR_PWR_STATE, 64'd2);
        mmio_write(9'h051, CSR_PWR_STATE, 64'hFFFF_FFFF_FFFF_FFFF);
        mmio_read(9'h052, CSR_PWR_STATE, 64'd2);
        @(posedge ccip_to_afu);
        pwr_state <= 2'b01;
        mmio_read(9'h053, CSR_PWR_STATE, 64'd1);
        finish_test("power state");
    endtask

    task automatic test_back_pressure();
        int waited;
        @(posedge ccip_to_afu);
        host_rsp_ready <= 1'b0;
        // The first read is held in the egress and the next two fill the queue
        send_req(MMIO_READ, 9'h101, CSR_AFU_ID, 64'd0);
        send_req(MMIO_READ, 9'h102, CSR_SCRATCH, 64'd0);
        send_req(MMIO_READ, 9'h103, CSR_WR_COUNT, 64'd0);
        waited = 0;
        @(negedge ccip_to_afu);
        while (host_req_ready && waited < wait_limit)
        begin
            waited++;
            @(negedge ccip_to_afu);
        end
        checks++;
        if (host_req_ready)
        begin
            errors++;
            $display("timeout at %0t: host_req_ready did not drop with the queue full", $time);
        end
        // The waiting response is the first read and must not change at all
        held.valid = 1'b1;
        held.tid   = 9'h101;
        held.data  = test_afu_id;
        for (int i = 0; i < 7; i++)
        begin
            checks++;
            if (host_rsp !== held)
            begin
                errors++;
                $display("error at %0t: host_rsp expected %h actual %h", $time, held, host_rsp);
            end
            @(negedge ccip_to_afu);
        end
        @(posedge ccip_to_afu);
        host_rsp_ready <= 1'b1;
        wait_rsp(9'h101, test_afu_id);
        wait_rsp(9'h102, exp_scratch);
        wait_rsp(9'h103, exp_wr_count);
        finish_test("back-pressure");
    endtask

    task automatic test_soft_reset();
        mmio_write(9'h060, CSR_SCRATCH, 64'h0F0F_1111_2222_3333);
        @(posedge ccip_to_afu);
        soft_reset <= 1'b1;
        @(posedge ccip_to_afu);
        soft_reset <= 1'b0;
        // The AFU reset is registered, so give it time to pass
        repeat (3) @(posedge ccip_to_afu);
        exp_wr_count = 64'd0;
        exp_scratch  = 64'd0;
        mmio_read(9'h061, CSR_SCRATCH, exp_scratch);
        mmio_read(9'h062, CSR_WR_COUNT, exp_wr_count);
        mmio_read(9'h063, CSR_AFU_ID, test_afu_id);
        finish_test("soft reset");
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        ccip_to_afu    = 1'b0;
        rst_n          = 1'b0;
        soft_reset     = 1'b0;
        pwr_state      = 2'b00;
        host_req       = '0;
        host_rsp_ready = 1'b0;
        seed           = 32'had3b4f46;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        err_mark       = 0;
        exp_wr_count   = 64'd0;
        exp_scratch    = 64'd0;
        repeat (4) @(posedge ccip_to_afu);
        @(negedge ccip_to_afu);
        checks++;
        // The handshake outputs stay low while the shim is in reset
        if (host_req_ready !== 1'b0 || host_rsp.valid !== 1'b0)
        begin
            errors++;
            $display("error at %0t: host_req_ready or host_rsp.valid expected 0 actual %b %b",
                     $time, host_req_ready, host_rsp.valid);
        end
        @(posedge ccip_to_afu);
        rst_n          <= 1'b1;
        host_rsp_ready <= 1'b1;
        test_reset_values();
        test_scratch_and_count();
        test_power_state();
        test_back_pressure();
        test_soft_reset();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/plat_shim_pkg.sv
rtl/host_mmio_ingress.sv
rtl/afu_csr_block.sv
rtl/host_mmio_egress.sv
rtl/plat_shim_top.sv
testbench/plat_shim_tb.sv
